// File: design/coherence_defs.svh
// sizes shared by the MESI cache pair
// word addressed, one word per line
`ifndef COHERENCE_DEFS_SVH
`define COHERENCE_DEFS_SVH

`define CC_ADDR_WIDTH  6    // word address
`define CC_DATA_WIDTH  32
`define CC_N_SETS      8    // direct mapped L1
`define CC_N_CPUS      2
`define CC_MEM_LATENCY 2    // cycles per memory access

`define CC_INDEX_WIDTH $clog2(`CC_N_SETS)
`define CC_TAG_WIDTH   (`CC_ADDR_WIDTH - `CC_INDEX_WIDTH)

`endif

// File: design/coherence_pkg.sv
// cache side types: MESI line state, L1 entry and coherence statistics
`include "coherence_defs.svh"

package coherence_pkg;

    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_state_t;

    typedef struct packed {
        mesi_state_t                state;
        logic [`CC_TAG_WIDTH-1:0]   tag;    // upper address bits
        logic [`CC_DATA_WIDTH-1:0]  data;
    } cache_line_t;

    typedef struct packed {
        logic [15:0] to_e_transitions;
        logic [15:0] to_s_transitions;
        logic [15:0] invalidated_blocks;    // lost to a remote write
        logic [15:0] shared_blocks;         // demoted by a remote read
    } coherence_stats_t;

endpackage

// File: design/bus_pkg.sv
// bus side types: APB request, coherence bus request, snoop and replies
`include "coherence_defs.svh"

package bus_pkg;

    typedef struct packed {
        logic [`CC_ADDR_WIDTH-1:0]  paddr;
        logic [`CC_DATA_WIDTH-1:0]  pwdata;
        logic                       pwrite;
        logic                       psel;
        logic                       penable;
    } cpu_req_t;

    typedef enum logic [1:0] {
        BUS_RD,     // read miss
        BUS_RDX,    // write miss
        BUS_UPGR,   // write to a shared line
        BUS_WB      // dirty eviction
    } bus_kind_t;

    typedef struct packed {
        logic                       valid;
        bus_kind_t                  kind;
        logic [`CC_ADDR_WIDTH-1:0]  addr;
        logic [`CC_DATA_WIDTH-1:0]  data;
    } bus_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`CC_ADDR_WIDTH-1:0]  addr;
        logic                       invalidate;
    } snoop_t;

    typedef struct packed {
        logic                       done;
        logic                       hit;
        logic                       dirty;
        logic [`CC_DATA_WIDTH-1:0]  data;
    } snoop_resp_t;

    typedef struct packed {
        logic                       done;
        logic [`CC_DATA_WIDTH-1:0]  data;
        logic                       exclusive;  // no other copy
    } bus_resp_t;

endpackage

// File: design/l1_cache.sv
// direct mapped L1, one word per line, write-back and write-allocate
// APB slave front end; misses and upgrades go to the coherency unit,
// which also drives the snoop lookups
`timescale 1ns/100ps
`include "coherence_defs.svh"

module l1_cache (
    input  logic                        CLK,
    input  logic                        nRST,
    input  bus_pkg::cpu_req_t           cpu_req,
    input  logic                        cu_done,
    input  logic [`CC_DATA_WIDTH-1:0]   fill_data,
    input  coherence_pkg::mesi_state_t  fill_state,
    input  logic [`CC_ADDR_WIDTH-1:0]   snoop_addr,
    input  logic                        snoop_inv,
    input  logic                        snoop_req,
    output logic [`CC_DATA_WIDTH-1:0]   prdata,
    output logic                        pready,
    output bus_pkg::bus_req_t           cu_req,
    output coherence_pkg::cache_line_t  victim,
    output bus_pkg::snoop_resp_t        snoop_resp
);
    localparam int IW = `CC_INDEX_WIDTH;

    coherence_pkg::mesi_state_t     state_q [`CC_N_SETS];
    logic [`CC_TAG_WIDTH-1:0]       tag_q   [`CC_N_SETS];
    logic [`CC_DATA_WIDTH-1:0]      data_q  [`CC_N_SETS];

    logic [IW-1:0] idx;
    logic [IW-1:0] s_idx;
    logic          access;
    logic          hit;
    logic          fast_hit;
    logic          write_hit;
    logic          s_hit;

    assign idx    = cpu_req.paddr[IW-1:0];
    assign s_idx  = snoop_addr[IW-1:0];
    assign access = cpu_req.psel && cpu_req.penable;
    assign hit    = state_q[idx] != coherence_pkg::INVALID &&
                    tag_q[idx] == cpu_req.paddr[`CC_ADDR_WIDTH-1:IW];
    // reads hit in any valid state, writes only in M or E
    assign fast_hit = hit && (!cpu_req.pwrite || state_q[idx] != coherence_pkg::SHARED);

    // a snoop lookup owns the arrays for its cycle
    assign write_hit = access && fast_hit && cpu_req.pwrite && !snoop_req;
    assign pready    = access && ((fast_hit && !snoop_req) || cu_done);
    assign prdata    = cu_done ? fill_data : data_q[idx];

    always_comb begin
        cu_req.valid = access && !fast_hit;
        if (hit) begin
            cu_req.kind = bus_pkg::BUS_UPGR;    // write to a shared line
        end else begin
            cu_req.kind = cpu_req.pwrite ? bus_pkg::BUS_RDX : bus_pkg::BUS_RD;
        end
        cu_req.addr = cpu_req.paddr;
        cu_req.data = cpu_req.pwdata;
    end

    assign victim = '{state: state_q[idx], tag: tag_q[idx], data: data_q[idx]};

    assign s_hit = state_q[s_idx] != coherence_pkg::INVALID &&
                   tag_q[s_idx] == snoop_addr[`CC_ADDR_WIDTH-1:IW];
    assign snoop_resp = '{
        done:  snoop_req,
        hit:   snoop_req && s_hit,
        dirty: snoop_req && s_hit && state_q[s_idx] == coherence_pkg::MODIFIED,
        data:  data_q[s_idx]
    };

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `CC_N_SETS; i++) begin
                state_q[i] <= coherence_pkg::INVALID;
            end
        end else if (cu_done) begin
            state_q[idx] <= fill_state;
        end else if (snoop_req && s_hit) begin
            state_q[s_idx] <= snoop_inv ? coherence_pkg::INVALID : coherence_pkg::SHARED;
        end else if (write_hit) begin
            state_q[idx] <= coherence_pkg::MODIFIED;   // E becomes M silently
        end
    end

    always_ff @(posedge CLK) begin
        if (cu_done) begin
            tag_q[idx]  <= cpu_req.paddr[`CC_ADDR_WIDTH-1:IW];
            data_q[idx] <= cpu_req.pwrite ? cpu_req.pwdata : fill_data;
        end else if (write_hit) begin
            data_q[idx] <= cpu_req.pwdata;
        end
    end

    a_penable_needs_psel: assert property (@(posedge CLK) disable iff (!nRST)
        cpu_req.penable |-> cpu_req.psel);

endmodule

// File: design/coherency_unit.sv
// per-core MESI coherency unit
// turns misses, upgrades and dirty evictions into bus transactions,
// answers snoops from the other core and counts state transitions
`timescale 1ns/100ps
`include "coherence_defs.svh"

module coherency_unit (
    input  logic                            CLK,
    input  logic                            nRST,
    input  bus_pkg::bus_req_t               cu_req,
    input  coherence_pkg::cache_line_t      victim,
    input  bus_pkg::snoop_t                 snoop,
    input  bus_pkg::snoop_resp_t            snoop_resp,
    input  bus_pkg::bus_resp_t              bus_resp,
    output logic                            cu_done,
    output logic [`CC_DATA_WIDTH-1:0]       fill_data,
    output coherence_pkg::mesi_state_t      fill_state,
    output logic [`CC_ADDR_WIDTH-1:0]       snoop_addr,
    output logic                            snoop_inv,
    output logic                            snoop_req,
    output bus_pkg::bus_req_t               bus_req,
    output bus_pkg::snoop_resp_t            snoop_reply,
    output coherence_pkg::coherence_stats_t stats
);
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        READ_REQ,
        WRITE_REQ,
        RESP_CHKTAG,
        RESP_SEND,
        RESP_FAIL
    } cu_state_t;

    cu_state_t            state_q;
    cu_state_t            state_d;
    bus_pkg::snoop_resp_t lookup_q;     // L1 answer held while replying
    logic                 req_state;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == RESP_CHKTAG) begin
            lookup_q <= snoop_resp;
        end
    end

    // an incoming snoop always wins, so two waiting cores cannot deadlock
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (snoop.valid) begin
                    state_d = RESP_CHKTAG;
                end else if (cu_req.valid) begin
                    if (victim.state == coherence_pkg::MODIFIED) begin
                        state_d = WRITEBACK;    // dirty victim leaves first
                    end else begin
                        state_d = cu_req.kind == bus_pkg::BUS_RD ? READ_REQ : WRITE_REQ;
                    end
                end
            end
            WRITEBACK: begin
                if (snoop.valid) begin
                    state_d = RESP_CHKTAG;
                end else if (bus_resp.done) begin
                    state_d = cu_req.kind == bus_pkg::BUS_RD ? READ_REQ : WRITE_REQ;
                end
            end
            READ_REQ, WRITE_REQ: begin
                if (snoop.valid) begin
                    state_d = RESP_CHKTAG;  // withdraw, retry from IDLE
                end else if (bus_resp.done) begin
                    state_d = IDLE;
                end
            end
            RESP_CHKTAG: state_d = snoop_resp.hit ? RESP_SEND : RESP_FAIL;
            RESP_SEND, RESP_FAIL: begin
                if (!snoop.valid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign req_state  = state_q == READ_REQ || state_q == WRITE_REQ;
    assign cu_done    = req_state && bus_resp.done;
    assign fill_data  = bus_resp.data;
    assign fill_state = state_q == WRITE_REQ ? coherence_pkg::MODIFIED :
                        bus_resp.exclusive   ? coherence_pkg::EXCLUSIVE : coherence_pkg::SHARED;
    assign snoop_addr = snoop.addr;
    assign snoop_inv  = snoop.invalidate;
    assign snoop_req  = state_q == RESP_CHKTAG;

    always_comb begin
        bus_req       = cu_req;
        bus_req.valid = req_state || state_q == WRITEBACK;
        if (state_q == WRITEBACK) begin
            bus_req.kind = bus_pkg::BUS_WB;
            bus_req.addr = {victim.tag, cu_req.addr[`CC_INDEX_WIDTH-1:0]};
            bus_req.data = victim.data;
        end
    end

    always_comb begin
        snoop_reply       = lookup_q;
        snoop_reply.done  = state_q == RESP_SEND || state_q == RESP_FAIL;
        snoop_reply.hit   = state_q == RESP_SEND;
        snoop_reply.dirty = state_q == RESP_SEND && lookup_q.dirty;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stats <= '0;
        end else if (state_q == READ_REQ && bus_resp.done) begin
            if (bus_resp.exclusive) begin
                stats.to_e_transitions <= stats.to_e_transitions + 16'd1;
            end else begin
                stats.to_s_transitions <= stats.to_s_transitions + 16'd1;
            end
        end else if (state_q == RESP_CHKTAG && snoop_resp.hit) begin
            if (snoop.invalidate) begin
                stats.invalidated_blocks <= stats.invalidated_blocks + 16'd1;
            end else begin
                stats.shared_blocks <= stats.shared_blocks + 16'd1;
            end
        end
    end

    // a request is only dropped on done or to answer a snoop
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        bus_req.valid && !bus_resp.done && !snoop.valid |=> bus_req.valid);

    a_hit_with_done: assert property (@(posedge CLK) disable iff (!nRST)
        snoop_reply.hit |-> snoop_reply.done);

endmodule

// File: design/bus_controller.sv
// snooping bus controller for two cores
// round-robin grant, snoop of the other core, dirty data forwarding
// and the word memory behind the bus
`timescale 1ns/100ps
`include "coherence_defs.svh"

module bus_controller (
    input  logic                    CLK,
    input  logic                    nRST,
    input  bus_pkg::bus_req_t       bus_req0,
    input  bus_pkg::bus_req_t       bus_req1,
    input  bus_pkg::snoop_resp_t    snoop_reply0,
    input  bus_pkg::snoop_resp_t    snoop_reply1,
    output bus_pkg::snoop_t         snoop0,
    output bus_pkg::snoop_t         snoop1,
    output bus_pkg::bus_resp_t      bus_resp0,
    output bus_pkg::bus_resp_t      bus_resp1
);
    localparam int CW = $clog2(`CC_MEM_LATENCY) + 1;

    typedef enum logic [1:0] {BC_IDLE, BC_SNOOP, BC_MEM, BC_RESP} bc_state_t;

    bc_state_t                  state_q;
    logic                       gnt_q;      // current owner, also last winner
    logic [CW-1:0]              cnt_q;
    bus_pkg::bus_req_t          cur_q;
    logic [`CC_DATA_WIDTH-1:0]  rdata_q;
    logic                       excl_q;
    logic [`CC_DATA_WIDTH-1:0]  mem [2**`CC_ADDR_WIDTH];

    logic                   pick;
    bus_pkg::bus_req_t      pick_req;
    bus_pkg::snoop_resp_t   remote;
    logic                   supply;
    logic                   mem_last;
    logic                   snoop_go;
    logic                   resp_go;

    // on a tie the core that lost last time wins
    assign pick     = (bus_req0.valid && bus_req1.valid) ? !gnt_q : bus_req1.valid;
    assign pick_req = pick ? bus_req1 : bus_req0;
    assign remote   = gnt_q ? snoop_reply0 : snoop_reply1;
    assign supply   = remote.done && remote.hit && remote.dirty;
    assign mem_last = cnt_q == CW'(`CC_MEM_LATENCY - 1);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= BC_IDLE;
            gnt_q   <= 1'b1;    // core 0 first
            cnt_q   <= '0;
        end else begin
            case (state_q)
                BC_IDLE: begin
                    cnt_q <= '0;
                    if (bus_req0.valid || bus_req1.valid) begin
                        gnt_q   <= pick;
                        state_q <= pick_req.kind == bus_pkg::BUS_WB ? BC_MEM : BC_SNOOP;
                    end
                end
                BC_SNOOP: begin
                    if (remote.done) begin
                        state_q <= supply ? BC_RESP : BC_MEM;
                    end
                end
                BC_MEM: begin
                    if (mem_last) begin
                        state_q <= BC_RESP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= BC_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        case (state_q)
            BC_IDLE: cur_q <= pick_req;
            BC_SNOOP: begin
                if (remote.done) begin
                    excl_q  <= !remote.hit;
                    rdata_q <= remote.data;
                end
                if (supply) begin
                    mem[cur_q.addr] <= remote.data;    // memory catches the dirty copy
                end
            end
            BC_MEM: begin
                if (mem_last && cur_q.kind == bus_pkg::BUS_WB) begin
                    mem[cur_q.addr] <= cur_q.data;
                end else if (mem_last) begin
                    rdata_q <= mem[cur_q.addr];
                end
            end
            default: ;
        endcase
    end

    assign snoop_go = state_q == BC_SNOOP;
    assign resp_go  = state_q == BC_RESP;

    // RDX and UPGR invalidate the other copy, RD only demotes it
    assign snoop0 = '{valid: snoop_go && gnt_q, addr: cur_q.addr,
                      invalidate: cur_q.kind != bus_pkg::BUS_RD};
    assign snoop1 = '{valid: snoop_go && !gnt_q, addr: cur_q.addr,
                      invalidate: cur_q.kind != bus_pkg::BUS_RD};

    assign bus_resp0 = '{done: resp_go && !gnt_q, data: rdata_q, exclusive: excl_q};
    assign bus_resp1 = '{done: resp_go && gnt_q, data: rdata_q, exclusive: excl_q};

    a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
        !(bus_resp0.done && bus_resp1.done));

endmodule

// File: design/coherent_pair_top.sv
// two-core MESI cache pair on one snooping bus
// per core an APB L1 and a coherency unit, one shared bus controller
`timescale 1ns/100ps
`include "coherence_defs.svh"

module coherent_pair_top (
    input  logic                            CLK,
    input  logic                            nRST,
    input  bus_pkg::cpu_req_t               cpu0,
    input  bus_pkg::cpu_req_t               cpu1,
    output logic [`CC_DATA_WIDTH-1:0]       prdata0,
    output logic [`CC_DATA_WIDTH-1:0]       prdata1,
    output logic                            pready0,
    output logic                            pready1,
    output coherence_pkg::coherence_stats_t stats0,
    output coherence_pkg::coherence_stats_t stats1
);
    bus_pkg::cpu_req_t                  cpu         [`CC_N_CPUS];
    logic [`CC_DATA_WIDTH-1:0]          prdata      [`CC_N_CPUS];
    logic                               pready      [`CC_N_CPUS];
    coherence_pkg::coherence_stats_t    stats       [`CC_N_CPUS];
    bus_pkg::bus_req_t                  cu_req      [`CC_N_CPUS];
    coherence_pkg::cache_line_t         victim      [`CC_N_CPUS];
    logic                               cu_done     [`CC_N_CPUS];
    logic [`CC_DATA_WIDTH-1:0]          fill_data   [`CC_N_CPUS];
    coherence_pkg::mesi_state_t         fill_state  [`CC_N_CPUS];
    logic [`CC_ADDR_WIDTH-1:0]          snoop_addr  [`CC_N_CPUS];
    logic                               snoop_inv   [`CC_N_CPUS];
    logic                               snoop_req   [`CC_N_CPUS];
    bus_pkg::snoop_resp_t               snoop_resp  [`CC_N_CPUS];   // L1 to unit
    bus_pkg::snoop_resp_t               snoop_reply [`CC_N_CPUS];   // unit to bus
    bus_pkg::snoop_t                    snoop       [`CC_N_CPUS];
    bus_pkg::bus_req_t                  bus_req     [`CC_N_CPUS];
    bus_pkg::bus_resp_t                 bus_resp    [`CC_N_CPUS];

    assign cpu[0]  = cpu0;
    assign cpu[1]  = cpu1;
    assign prdata0 = prdata[0];
    assign prdata1 = prdata[1];
    assign pready0 = pready[0];
    assign pready1 = pready[1];
    assign stats0  = stats[0];
    assign stats1  = stats[1];

    for (genvar i = 0; i < `CC_N_CPUS; i++) begin : g_core
        l1_cache i_l1 (
            .CLK        (CLK),
            .nRST       (nRST),
            .cpu_req    (cpu[i]),
            .cu_done    (cu_done[i]),
            .fill_data  (fill_data[i]),
            .fill_state (fill_state[i]),
            .snoop_addr (snoop_addr[i]),
            .snoop_inv  (snoop_inv[i]),
            .snoop_req  (snoop_req[i]),
            .prdata     (prdata[i]),
            .pready     (pready[i]),
            .cu_req     (cu_req[i]),
            .victim     (victim[i]),
            .snoop_resp (snoop_resp[i])
        );

        coherency_unit i_cu (
            .CLK         (CLK),
            .nRST        (nRST),
            .cu_req      (cu_req[i]),
            .victim      (victim[i]),
            .snoop       (snoop[i]),
            .snoop_resp  (snoop_resp[i]),
            .bus_resp    (bus_resp[i]),
            .cu_done     (cu_done[i]),
            .fill_data   (fill_data[i]),
            .fill_state  (fill_state[i]),
            .snoop_addr  (snoop_addr[i]),
            .snoop_inv   (snoop_inv[i]),
            .snoop_req   (snoop_req[i]),
            .bus_req     (bus_req[i]),
            .snoop_reply (snoop_reply[i]),
            .stats       (stats[i])
        );
    end

    bus_controller i_bus (
        .CLK          (CLK),
        .nRST         (nRST),
        .bus_req0     (bus_req[0]),
        .bus_req1     (bus_req[1]),
        .snoop_reply0 (snoop_reply[0]),
        .snoop_reply1 (snoop_reply[1]),
        .snoop0       (snoop[0]),
        .snoop1       (snoop[1]),
        .bus_resp0    (bus_resp[0]),
        .bus_resp1    (bus_resp[1])
    );

endmodule

// File: verif/coherent_pair_tb.sv
// testbench for the two-core MESI cache pair
// LFSR driven APB traffic on both cores, checked against a coherence model
`timescale 1ns/100ps
`include "coherence_defs.svh"

module coherent_pair_tb;
    localparam int IW          = `CC_INDEX_WIDTH;
    localparam int N_FILL      = 16;
    localparam int N_DIRECTED  = 5;
    localparam int N_RANDOM    = 300;
    localparam int WORST_LAT   = 16;    // setup, writeback, snoop, memory, response
    localparam int CYCLE_LIMIT = (N_FILL + N_DIRECTED + N_RANDOM) * WORST_LAT * 2;

    logic                               CLK;
    logic                               nRST;
    bus_pkg::cpu_req_t                  cpu     [2];
    logic [`CC_DATA_WIDTH-1:0]          prdata  [2];
    logic                               pready  [2];
    coherence_pkg::coherence_stats_t    stats   [2];

    logic [`CC_DATA_WIDTH-1:0]          m_mem   [2**`CC_ADDR_WIDTH];    // coherent value
    coherence_pkg::mesi_state_t         m_state [2][`CC_N_SETS];
    logic [`CC_TAG_WIDTH-1:0]           m_tag   [2][`CC_N_SETS];
    coherence_pkg::coherence_stats_t    m_stats [2];

    logic [15:0] lfsr;
    int          cycles;
    int          n_tests;
    int          n_checks;
    int          n_errors;
    int          test_checks;
    int          test_errors;

    coherent_pair_top i_dut (
        .CLK     (CLK),
        .nRST    (nRST),
        .cpu0    (cpu[0]),
        .cpu1    (cpu[1]),
        .prdata0 (prdata[0]),
        .prdata1 (prdata[1]),
        .pready0 (pready[0]),
        .pready1 (pready[1]),
        .stats0  (stats[0]),
        .stats1  (stats[1])
    );

    always #5 CLK = ~CLK;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};   // one step per bit
        end
        return bits;
    endfunction

    // four tags on each of four sets, so lines keep colliding
    function automatic logic [`CC_ADDR_WIDTH-1:0] pool_addr(input logic [3:0] n);
        return {1'b0, n[3:2], 1'b0, n[1:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_core_stats(input logic c);
        check_value($sformatf("stats%0d.to_e_transitions", c),
                    32'(stats[c].to_e_transitions), 32'(m_stats[c].to_e_transitions));
        check_value($sformatf("stats%0d.to_s_transitions", c),
                    32'(stats[c].to_s_transitions), 32'(m_stats[c].to_s_transitions));
        check_value($sformatf("stats%0d.invalidated_blocks", c),
                    32'(stats[c].invalidated_blocks), 32'(m_stats[c].invalidated_blocks));
        check_value($sformatf("stats%0d.shared_blocks", c),
                    32'(stats[c].shared_blocks), 32'(m_stats[c].shared_blocks));
    endtask

    // MESI rules for one completed transfer
    task automatic model_update(input logic c, input logic wr,
                                input logic [`CC_ADDR_WIDTH-1:0] a,
                                input logic [`CC_DATA_WIDTH-1:0] d);
        logic                     o;
        logic [IW-1:0]            set;
        logic [`CC_TAG_WIDTH-1:0] tag;
        logic                     own_hit;
        logic                     other_hit;
        o         = !c;
        set       = a[IW-1:0];
        tag       = a[`CC_ADDR_WIDTH-1:IW];
        own_hit   = m_state[c][set] != coherence_pkg::INVALID && m_tag[c][set] == tag;
        other_hit = m_state[o][set] != coherence_pkg::INVALID && m_tag[o][set] == tag;
        if (!wr) begin
            if (!own_hit && other_hit) begin   // remote copy demoted
                m_state[o][set] = coherence_pkg::SHARED;
                m_stats[o].shared_blocks += 16'd1;
                m_stats[c].to_s_transitions += 16'd1;
                m_state[c][set] = coherence_pkg::SHARED;
            end else if (!own_hit) begin
                m_stats[c].to_e_transitions += 16'd1;
                m_state[c][set] = coherence_pkg::EXCLUSIVE;
            end
        end else begin
            if ((!own_hit || m_state[c][set] == coherence_pkg::SHARED) && other_hit) begin
                m_state[o][set] = coherence_pkg::INVALID;
                m_stats[o].invalidated_blocks += 16'd1;
            end
            m_state[c][set] = coherence_pkg::MODIFIED;
            m_mem[a] = d;
        end
        m_tag[c][set] = tag;
    endtask

    task automatic do_transfer(input logic c, input logic wr,
                               input logic [`CC_ADDR_WIDTH-1:0] a,
                               input logic [`CC_DATA_WIDTH-1:0] d);
        logic [`CC_DATA_WIDTH-1:0] got;
        logic [`CC_DATA_WIDTH-1:0] exp;
        logic                      ready;
        exp = m_mem[a];
        @(posedge CLK);
        cpu[c].paddr  <= a;     // setup phase
        cpu[c].pwdata <= d;
        cpu[c].pwrite <= wr;
        cpu[c].psel   <= 1'b1;
        @(posedge CLK);
        cpu[c].penable <= 1'b1;
        ready = 1'b0;
        while (!ready) begin
            @(negedge CLK);
            ready = pready[c];
        end
        got = prdata[c];
        @(posedge CLK);
        cpu[c].psel    <= 1'b0;  // transfer completes on this edge
        cpu[c].penable <= 1'b0;
        model_update(c, wr, a, d);
        @(negedge CLK);
        if (!wr) begin
            check_value($sformatf("prdata%0d", c), got, exp);
        end
        check_core_stats(1'b0);
        check_core_stats(1'b1);
    endtask

    task automatic end_test(input string name);
        n_tests++;
        n_checks += test_checks;
        n_errors += test_errors;
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: an APB transfer did not get pready within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic        c;
        logic        wr;
        logic [3:0]  n;
        CLK     = 1'b0;
        nRST    = 1'b0;
        cpu     = '{default: '0};
        lfsr    = 16'd61;
        m_state = '{default: coherence_pkg::INVALID};
        m_tag   = '{default: '0};
        m_stats = '{default: '0};
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        test_checks = 0;
        test_errors = 0;
        repeat (3) @(posedge CLK);
        cpu[0].psel    <= 1'b1;   // read of address 0 pending while in reset
        cpu[0].penable <= 1'b1;
        cpu[1].psel    <= 1'b1;
        cpu[1].penable <= 1'b1;
        @(negedge CLK);
        check_value("pready0", 32'(pready[0]), 32'd0);  // lines invalid, no done
        check_value("pready1", 32'(pready[1]), 32'd0);
        @(posedge CLK);
        nRST <= 1'b1;
        cpu[0].psel    <= 1'b0;
        cpu[0].penable <= 1'b0;
        cpu[1].psel    <= 1'b0;
        cpu[1].penable <= 1'b0;
        @(negedge CLK);
        check_core_stats(1'b0);
        check_core_stats(1'b1);
        end_test("reset");

        for (int i = 0; i < N_FILL; i++) begin
            do_transfer(i[0], 1'b1, pool_addr(4'(i)), take_bits(32));
        end
        end_test("fill");

        do_transfer(1'b0, 1'b1, 6'h01, take_bits(32));
        do_transfer(1'b1, 1'b0, 6'h01, '0);    // dirty supply from core 0
        do_transfer(1'b0, 1'b1, 6'h01, take_bits(32));  // upgrade kills core 1 copy
        do_transfer(1'b1, 1'b0, 6'h01, '0);
        do_transfer(1'b0, 1'b0, 6'h08, '0);    // dirty victim, no remote copy
        end_test("sharing");

        for (int i = 0; i < N_RANDOM; i++) begin
            r  = take_bits(1);
            c  = r[0];
            r  = take_bits(1);
            wr = r[0];
            r  = take_bits(4);
            n  = r[3:0];
            do_transfer(c, wr, pool_addr(n), take_bits(32));
        end
        end_test("random");

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/coherence_pkg.sv
design/bus_pkg.sv
design/l1_cache.sv
design/coherency_unit.sv
design/bus_controller.sv
design/coherent_pair_top.sv
verif/coherent_pair_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = coherent_pair_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
